//--- project.f
+incdir+hdl
hdl/xbuf_pkg.sv
hdl/x_row_fetcher.sv
hdl/x_transpose_buffer.sv
hdl/x_tile_consumer.sv
hdl/x_stream_top.sv
verification/wb_mem_model.sv
verification/tb_x_stream.sv

//--- Makefile
# Verilator build and run of the X stream testbench
.PHONY: sim clean

sim:
	verilator --binary --timing -f project.f --top-module tb_x_stream \
		-Mdir obj_dir -o sim_x_stream
	./obj_dir/sim_x_stream | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_x_stream.sv
// Self-checking testbench for x_stream_top; runs must fit in MEM_WORDS words without wrapping
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_cfg.svh"

module tb_x_stream
  import xbuf_pkg::*;
();

  localparam int MEM_WORDS      = 64;
  localparam int TIMEOUT_CYCLES = 2000;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       start;
  logic [`XBUF_AW-1:0]        base_addr;
  logic [`XBUF_ROWS_W-1:0]    num_rows;
  xbuf_elem_t [`XBUF_H-1:0]   weight;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [`XBUF_AW-1:0]        wb_adr;
  logic [`XBUF_DW/8-1:0]      wb_sel;
  logic [`XBUF_DW-1:0]        wb_dat;
  logic                       wb_ack;
  logic                       result_valid;
  xbuf_acc_t [`XBUF_W-1:0]    result;
  logic                       result_ready;
  logic                       busy;

  logic [`XBUF_DW-1:0]        mem_image [MEM_WORDS];
  xbuf_acc_t                  exp_q [$];
  xbuf_acc_t [`XBUF_W-1:0]    held_result;
  logic                       hold_pending;
  integer                     seed;
  int                         err_count;
  int                         timeout_count;
  int                         res_count;

  x_stream_top u_x_stream_top (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .start_i        ( start        ),
    .base_addr_i    ( base_addr    ),
    .num_rows_i     ( num_rows     ),
    .weight_i       ( weight       ),
    .wb_cyc_o       ( wb_cyc       ),
    .wb_stb_o       ( wb_stb       ),
    .wb_we_o        ( wb_we        ),
    .wb_adr_o       ( wb_adr       ),
    .wb_sel_o       ( wb_sel       ),
    .wb_dat_i       ( wb_dat       ),
    .wb_ack_i       ( wb_ack       ),
    .result_valid_o ( result_valid ),
    .result_o       ( result       ),
    .result_ready_i ( result_ready ),
    .busy_o         ( busy         )
  );

  wb_mem_model #(.MEM_WORDS(MEM_WORDS)) u_wb_mem (
    .clk_i    ( clk_i  ),
    .rst_ni   ( rst_ni ),
    .wb_cyc_i ( wb_cyc ),
    .wb_stb_i ( wb_stb ),
    .wb_adr_i ( wb_adr ),
    .wb_dat_o ( wb_dat ),
    .wb_ack_o ( wb_ack )
  );

  always #20 clk_i = ~clk_i;

  task automatic check_acc(input string name, input xbuf_acc_t actual, input xbuf_acc_t expected);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, actual, expected);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, actual, expected);
      err_count++;
    end
  endtask

  task automatic check_sel(input string name, input logic [`XBUF_DW/8-1:0] actual,
                           input logic [`XBUF_DW/8-1:0] expected);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, actual, expected);
      err_count++;
    end
  endtask

  // Element value mixes the full word index with the column
  function automatic xbuf_elem_t elem_pattern(input int idx, input int col, input int salt);
    return xbuf_elem_t'(idx * 521 + col * 4099 + salt);
  endfunction

  task automatic load_memory(input int salt);
    xbuf_word_u word;
    for (int i = 0; i < MEM_WORDS; i++) begin
      for (int e = 0; e < `XBUF_W; e++) begin
        word.elem[e] = elem_pattern(i, e, salt);
      end
      mem_image[i]      = word.raw;
      u_wb_mem.mem[i]   = word.raw;
    end
  endtask

  // Expected sum for one column of tile k; rows past the run count as zeros
  function automatic xbuf_acc_t ref_col_sum(input logic [`XBUF_DW-1:0] image [MEM_WORDS],
                                            input int base_byte, input int rows, input int tile,
                                            input int col, input xbuf_elem_t [`XBUF_H-1:0] wts);
    xbuf_word_u word;
    longint     sum;
    int         row;
    sum = 0;
    for (int h = 0; h < `XBUF_H; h++) begin
      row = tile * `XBUF_H + h;
      if (row < rows) begin
        word.raw = image[(base_byte / (`XBUF_DW / 8) + row) % MEM_WORDS];
        sum = sum + longint'(wts[h]) * longint'(word.elem[col]);
      end
    end
    return xbuf_acc_t'(sum);
  endfunction

  // Read-only master, strobe follows cycle and all byte lanes are enabled
  always @(posedge clk_i) begin : bus_checks
    if (rst_ni) begin
      check_bit("wb_stb_o", wb_stb, wb_cyc);
      if (wb_cyc) begin
        check_bit("wb_we_o", wb_we, 1'b0);
        check_sel("wb_sel_o", wb_sel, {(`XBUF_DW/8){1'b1}});
      end
    end
  end

  // Takes every accepted result in order and checks that held results stay put
  always @(posedge clk_i) begin : compare_results
    xbuf_acc_t expected;
    if (rst_ni) begin
      if (hold_pending && result_valid) begin
        for (int w = 0; w < `XBUF_W; w++) begin
          check_acc($sformatf("held result_o[%0d]", w), result[w], held_result[w]);
        end
      end
      if (result_valid && result_ready) begin
        if (exp_q.size() < `XBUF_W) begin
          $display("Unexpected result accepted at %0t with nothing left to compare", $time);
          err_count++;
        end else begin
          for (int w = 0; w < `XBUF_W; w++) begin
            expected = exp_q.pop_front();
            check_acc($sformatf("result_o[%0d]", w), result[w], expected);
          end
        end
        res_count++;
      end
      hold_pending = result_valid && !result_ready;
      held_result  = result;
    end
  end

  task automatic run_case(input int base_word, input int rows, input bit backpressure);
    int     tiles;
    int     target;
    int     wait_cycles;
    integer draw;
    tiles  = (rows + `XBUF_H - 1) / `XBUF_H;
    target = res_count + tiles;
    for (int k = 0; k < tiles; k++) begin
      for (int w = 0; w < `XBUF_W; w++) begin
        exp_q.push_back(ref_col_sum(mem_image, base_word * (`XBUF_DW / 8), rows, k, w, weight));
      end
    end
    base_addr    = `XBUF_AW'(base_word * (`XBUF_DW / 8));
    num_rows     = `XBUF_ROWS_W'(rows);
    start        = 1'b1;
    result_ready = !backpressure;
    @(negedge clk_i);
    start = 1'b0;
    check_bit("busy_o after start", busy, 1'b1);
    wait_cycles = 0;
    while (res_count < target && wait_cycles < TIMEOUT_CYCLES) begin
      if (backpressure) begin
        draw = $random(seed);
        result_ready = draw[0];
      end
      @(negedge clk_i);
      wait_cycles++;
    end
    result_ready = 1'b1;
    if (res_count < target) begin
      $display("Timeout in run of %0d rows: %0d of %0d results arrived",
               rows, tiles - (target - res_count), tiles);
      timeout_count++;
    end else begin
      check_bit("busy_o after last result", busy, 1'b0);
      // Quiet window to catch extra results
      repeat (4 * `XBUF_H) @(negedge clk_i);
      if (res_count != target) begin
        $display("Run of %0d rows gave %0d results instead of %0d",
                 rows, tiles + res_count - target, tiles);
        err_count++;
      end
    end
  endtask

  initial begin : stimulus
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    start         = 1'b0;
    base_addr     = '0;
    num_rows      = '0;
    weight        = '0;
    result_ready  = 1'b0;
    hold_pending  = 1'b0;
    seed          = 32'h64d8;
    err_count     = 0;
    timeout_count = 0;
    res_count     = 0;
    load_memory(3);
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("busy_o after reset", busy, 1'b0);

    weight[0] = 16'sd3;
    weight[1] = -16'sd2;
    weight[2] = 16'sd5;
    weight[3] = 16'sd1;
    run_case(0, 2 * `XBUF_H, 1'b0);
    if (timeout_count == 0) run_case(10, `XBUF_H + 1, 1'b0);
    if (timeout_count == 0) run_case(20, 5 * `XBUF_H, 1'b1);
    if (timeout_count == 0) run_case(45, 1, 1'b0);

    // Large magnitudes of both signs so the sums wrap
    load_memory(-30000);
    weight[0] = -16'sd32768;
    weight[1] = 16'sd32767;
    weight[2] = -16'sd1;
    weight[3] = -16'sd7;
    if (timeout_count == 0) run_case(50, 6, 1'b1);

    $display("Errors: %0d, timeouts: %0d, results: %0d", err_count, timeout_count, res_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/wb_mem_model.sv
// Read-only Wishbone classic slave for simulation; word address wraps at MEM_WORDS, filled by the testbench
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_cfg.svh"

module wb_mem_model #(
  parameter int unsigned MEM_WORDS = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic [`XBUF_AW-1:0] wb_adr_i,
  output logic [`XBUF_DW-1:0] wb_dat_o,
  output logic                wb_ack_o
);

  localparam int unsigned OFS_W = $clog2(`XBUF_DW / 8);
  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // One row per word, loaded by the testbench before each run
  logic [`XBUF_DW-1:0] mem [MEM_WORDS];

  integer     seed;
  logic       ack_q;
  logic       pending_q;
  logic [1:0] wait_q;

  initial seed = 32'h64d8;

  // Ack after 0 to 3 wait states, drawn when a request first shows up
  always @(posedge clk_i or negedge rst_ni) begin : ack_ctrl
    integer draw;
    if (!rst_ni) begin
      ack_q     <= 1'b0;
      pending_q <= 1'b0;
      wait_q    <= '0;
    end else begin
      ack_q <= 1'b0;
      if (wb_cyc_i && wb_stb_i && !ack_q) begin
        if (!pending_q) begin
          draw = $random(seed);
          wait_q    <= draw[1:0];
          pending_q <= (draw[1:0] != 2'd0);
          ack_q     <= (draw[1:0] == 2'd0);
        end else if (wait_q == 2'd1) begin
          pending_q <= 1'b0;
          ack_q     <= 1'b1;
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

  // Address is held until ack, so the read can be combinational
  assign wb_dat_o = ack_q ? mem[wb_adr_i[OFS_W +: IDX_W]] : '0;
  assign wb_ack_o = ack_q;

endmodule

`default_nettype wire

//--- hdl/x_stream_top.sv
// X operand stream; read-only Wishbone classic master, one run at a time, inputs held during a run
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_cfg.svh"

module x_stream_top
  import xbuf_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       start_i,
  input  logic [`XBUF_AW-1:0]        base_addr_i,
  input  logic [`XBUF_ROWS_W-1:0]    num_rows_i,
  input  xbuf_elem_t [`XBUF_H-1:0]   weight_i,
  // Wishbone classic master
  output logic                       wb_cyc_o,
  output logic                       wb_stb_o,
  output logic                       wb_we_o,
  output logic [`XBUF_AW-1:0]        wb_adr_o,
  output logic [`XBUF_DW/8-1:0]      wb_sel_o,
  input  logic [`XBUF_DW-1:0]        wb_dat_i,
  input  logic                       wb_ack_i,
  // Results
  output logic                       result_valid_o,
  output xbuf_acc_t [`XBUF_W-1:0]    result_o,
  input  logic                       result_ready_i,
  output logic                       busy_o
);

  logic                                  row_valid;
  xbuf_word_u                            row_data;
  logic                                  row_last;
  logic                                  row_ready;
  logic                                  tile_valid;
  xbuf_elem_t [`XBUF_W-1:0][`XBUF_H-1:0] tile_data;
  logic                                  tile_ack;
  logic                                  all_done;
  logic                                  busy_q;

  // Reads only, always full words
  assign wb_we_o  = 1'b0;
  assign wb_sel_o = '1;

  x_row_fetcher u_fetch (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .start_i      ( start_i     ),
    .base_addr_i  ( base_addr_i ),
    .num_rows_i   ( num_rows_i  ),
    .wb_cyc_o     ( wb_cyc_o    ),
    .wb_stb_o     ( wb_stb_o    ),
    .wb_adr_o     ( wb_adr_o    ),
    .wb_dat_i     ( wb_dat_i    ),
    .wb_ack_i     ( wb_ack_i    ),
    .row_valid_o  ( row_valid   ),
    .row_data_o   ( row_data    ),
    .row_last_o   ( row_last    ),
    .row_ready_i  ( row_ready   ),
    .fetch_done_o (             )
  );

  x_transpose_buffer u_buf (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .row_valid_i  ( row_valid  ),
    .row_data_i   ( row_data   ),
    .row_last_i   ( row_last   ),
    .row_ready_o  ( row_ready  ),
    .tile_valid_o ( tile_valid ),
    .tile_data_o  ( tile_data  ),
    .tile_ack_i   ( tile_ack   )
  );

  x_tile_consumer u_cons (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .num_rows_i     ( num_rows_i     ),
    .tile_valid_i   ( tile_valid     ),
    .tile_data_i    ( tile_data      ),
    .tile_ack_o     ( tile_ack       ),
    .weight_i       ( weight_i       ),
    .result_valid_o ( result_valid_o ),
    .result_o       ( result_o       ),
    .result_ready_i ( result_ready_i ),
    .all_done_o     ( all_done       )
  );

  // Busy from the cycle after start until the last result is taken
  always_ff @(posedge clk_i or negedge rst_ni) begin : busy_reg
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (start_i) begin
      busy_q <= 1'b1;
    end else if (all_done) begin
      busy_q <= 1'b0;
    end
  end

  assign busy_o = busy_q;

endmodule

`default_nettype wire

//--- hdl/x_tile_consumer.sv
// Weighted column sums wrap at XBUF_ACC_W; num_rows_i and weight_i must stay stable during a run
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_cfg.svh"

module x_tile_consumer
  import xbuf_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [`XBUF_ROWS_W-1:0]               num_rows_i,
  // Tile from the transpose buffer
  input  logic                                  tile_valid_i,
  input  xbuf_elem_t [`XBUF_W-1:0][`XBUF_H-1:0] tile_data_i,
  output logic                                  tile_ack_o,
  input  xbuf_elem_t [`XBUF_H-1:0]              weight_i,
  // Result towards the outside
  output logic                                  result_valid_o,
  output xbuf_acc_t [`XBUF_W-1:0]               result_o,
  input  logic                                  result_ready_i,
  output logic                                  all_done_o
);

  localparam int unsigned TILES_W = `XBUF_ROWS_W + 1;

  logic [TILES_W-1:0]      tiles_exp;
  logic [TILES_W-1:0]      tile_cnt_q;
  logic                    valid_q;
  xbuf_acc_t [`XBUF_W-1:0] result_q;
  xbuf_acc_t [`XBUF_W-1:0] sum_d;

  logic tile_accept;
  logic deliver;

  // Number of tiles in the run, a partial tail counts as one
  assign tiles_exp = (TILES_W'(num_rows_i) + TILES_W'(`XBUF_H - 1)) / TILES_W'(`XBUF_H);

  // A new tile is taken only into an empty output register
  assign tile_accept = tile_valid_i && !valid_q;
  assign deliver     = valid_q && result_ready_i;

  always_comb begin : col_sums
    for (int w = 0; w < `XBUF_W; w++) begin
      sum_d[w] = '0;
      for (int h = 0; h < `XBUF_H; h++) begin
        sum_d[w] = sum_d[w] + xbuf_acc_t'(weight_i[h]) * xbuf_acc_t'(tile_data_i[w][h]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : out_ctrl
    if (!rst_ni) begin
      valid_q    <= 1'b0;
      tile_cnt_q <= '0;
    end else begin
      if (tile_accept) begin
        valid_q <= 1'b1;
      end else if (deliver) begin
        valid_q <= 1'b0;
      end
      // Count delivered tiles and restart for the next run
      if (deliver) begin
        tile_cnt_q <= all_done_o ? '0 : tile_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : out_data
    if (tile_accept) begin
      result_q <= sum_d;
    end
  end

  assign tile_ack_o     = tile_accept;
  assign result_valid_o = valid_q;
  assign result_o       = result_q;
  assign all_done_o     = deliver && (tile_cnt_q == tiles_exp - TILES_W'(1));

endmodule

`default_nettype wire

//--- hdl/x_transpose_buffer.sv
// Two tile banks in ping-pong; a bank is only freed by tile_ack_i and rows need row_last_i per tile
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_cfg.svh"

module x_transpose_buffer
  import xbuf_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Row stream from the fetcher
  input  logic                                  row_valid_i,
  input  xbuf_word_u                            row_data_i,
  input  logic                                  row_last_i,
  output logic                                  row_ready_o,
  // Tile towards the consumer, column first
  output logic                                  tile_valid_o,
  output xbuf_elem_t [`XBUF_W-1:0][`XBUF_H-1:0] tile_data_o,
  input  logic                                  tile_ack_i
);

  localparam int unsigned HIDX_W = (`XBUF_H > 1) ? $clog2(`XBUF_H) : 1;

  // Bank storage, bank index first then row
  xbuf_word_u        bank_q [2][`XBUF_H];

  logic [1:0]        full_q;
  logic              wr_bank_q;
  logic              rd_bank_q;
  logic [HIDX_W-1:0] row_idx_q;

  logic row_accept;
  logic bank_complete;

  // Only the write bank decides whether a row can come in
  assign row_ready_o   = ~full_q[wr_bank_q];
  assign row_accept    = row_valid_i && row_ready_o;
  assign bank_complete = row_accept && (row_last_i || (row_idx_q == HIDX_W'(`XBUF_H - 1)));

  always_ff @(posedge clk_i or negedge rst_ni) begin : bank_ctrl
    if (!rst_ni) begin
      full_q    <= '0;
      wr_bank_q <= 1'b0;
      rd_bank_q <= 1'b0;
      row_idx_q <= '0;
    end else begin
      if (row_accept) begin
        row_idx_q <= bank_complete ? '0 : row_idx_q + 1'b1;
      end
      if (bank_complete) begin
        full_q[wr_bank_q] <= 1'b1;
        wr_bank_q         <= ~wr_bank_q;
      end
      // The read bank is always full when acked, so it never equals the write bank here
      if (tile_ack_i) begin
        full_q[rd_bank_q] <= 1'b0;
        rd_bank_q         <= ~rd_bank_q;
      end
    end
  end

  // Row write, with zero fill of the remaining rows on a short tile
  always_ff @(posedge clk_i) begin : bank_write
    if (row_accept) begin
      for (int h = 0; h < `XBUF_H; h++) begin
        if (HIDX_W'(h) == row_idx_q) begin
          bank_q[wr_bank_q][h] <= row_data_i;
        end else if (row_last_i && (HIDX_W'(h) > row_idx_q)) begin
          bank_q[wr_bank_q][h] <= '0;
        end
      end
    end
  end

  assign tile_valid_o = full_q[rd_bank_q];

  // Transposed view of the read bank: column w, row h is element w of row h
  for (genvar w = 0; w < `XBUF_W; w++) begin : g_col
    for (genvar h = 0; h < `XBUF_H; h++) begin : g_row
      assign tile_data_o[w][h] = bank_q[rd_bank_q][h].elem[w];
    end
  end

endmodule

`default_nettype wire

//--- hdl/x_row_fetcher.sv
// Reads one row per Wishbone classic read; start_i is ignored unless idle, num_rows_i >= 1
`timescale 1ns/1ps
`default_nettype none

`include "xbuf_cfg.svh"

module x_row_fetcher
  import xbuf_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     start_i,
  input  logic [`XBUF_AW-1:0]      base_addr_i,
  input  logic [`XBUF_ROWS_W-1:0]  num_rows_i,
  // Wishbone classic read master
  output logic                     wb_cyc_o,
  output logic                     wb_stb_o,
  output logic [`XBUF_AW-1:0]      wb_adr_o,
  input  logic [`XBUF_DW-1:0]      wb_dat_i,
  input  logic                     wb_ack_i,
  // Row stream towards the transpose buffer
  output logic                     row_valid_o,
  output xbuf_word_u               row_data_o,
  output logic                     row_last_o,
  input  logic                     row_ready_i,
  output logic                     fetch_done_o
);

  localparam int unsigned HIDX_W = (`XBUF_H > 1) ? $clog2(`XBUF_H) : 1;

  xbuf_fetch_state_e        state_q;
  logic                     cyc_q;
  logic                     valid_q;
  logic                     last_q;
  logic [`XBUF_AW-1:0]      adr_q;
  logic [`XBUF_ROWS_W-1:0]  left_q;
  logic [HIDX_W-1:0]        hcnt_q;
  xbuf_word_u               data_q;

  logic bus_done;
  logic row_accept;

  assign bus_done   = cyc_q && wb_ack_i;
  assign row_accept = valid_q && row_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : fetch_fsm
    if (!rst_ni) begin
      state_q <= IDLE;
      cyc_q   <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      adr_q   <= '0;
      left_q  <= '0;
      hcnt_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            adr_q   <= base_addr_i;
            left_q  <= num_rows_i;
            hcnt_q  <= '0;
            cyc_q   <= 1'b1;
            state_q <= REQ;
          end
        end

        REQ: begin
          // Bus cycle ends on ack, the word moves to the holding register
          if (bus_done) begin
            cyc_q   <= 1'b0;
            valid_q <= 1'b1;
            last_q  <= (hcnt_q == HIDX_W'(`XBUF_H - 1)) || (left_q == `XBUF_ROWS_W'(1));
            hcnt_q  <= (hcnt_q == HIDX_W'(`XBUF_H - 1)) ? '0 : hcnt_q + 1'b1;
            left_q  <= left_q - 1'b1;
            adr_q   <= adr_q + `XBUF_AW'(`XBUF_DW / 8);
          end
          // Next request only once the held row is gone
          if (row_accept) begin
            valid_q <= 1'b0;
            if (left_q == '0) begin
              state_q <= DONE;
            end else begin
              cyc_q <= 1'b1;
            end
          end
        end

        DONE: begin
          state_q <= IDLE;
        end

        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : hold_reg
    if (bus_done) begin
      data_q.raw <= wb_dat_i;
    end
  end

  assign wb_cyc_o     = cyc_q;
  assign wb_stb_o     = cyc_q;
  assign wb_adr_o     = adr_q;
  assign row_valid_o  = valid_q;
  assign row_data_o   = data_q;
  assign row_last_o   = last_q;
  assign fetch_done_o = (state_q == DONE);

endmodule

`default_nettype wire

//--- hdl/xbuf_pkg.sv
// Types shared by the X stream blocks; sizes come from xbuf_cfg.svh
`default_nettype none

`include "xbuf_cfg.svh"

package xbuf_pkg;

  // One signed integer element
  typedef logic signed [`XBUF_EW-1:0] xbuf_elem_t;

  // Bus word, seen either as raw bits or as a row of elements
  // Element 0 sits in the low bits
  typedef union packed {
    logic [`XBUF_DW-1:0]          raw;
    xbuf_elem_t [`XBUF_W-1:0]     elem;
  } xbuf_word_u;

  // Row fetcher states
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    DONE
  } xbuf_fetch_state_e;

  // Wrapped column sum
  typedef logic signed [`XBUF_ACC_W-1:0] xbuf_acc_t;

endpackage

`default_nettype wire

//--- hdl/xbuf_cfg.svh
// Array geometry; XBUF_DW must stay XBUF_W * XBUF_EW and a multiple of 8 bits
`ifndef XBUF_CFG_SVH
`define XBUF_CFG_SVH

// Elements per row, which is also the number of columns per tile
`define XBUF_W 4

// Rows per tile
`define XBUF_H 4

// Element width in bits
`define XBUF_EW 16

// One bus word carries one full row
`define XBUF_DW (`XBUF_W * `XBUF_EW)

// Byte address width of the memory port
`define XBUF_AW 32

// Width of one column result and of the row-count input
`define XBUF_ACC_W 32
`define XBUF_ROWS_W 8

`endif
